// File: Bender.yml
package:
  name: mfDemod

sources:
  - design/demodTypesPkg.sv
  - design/mfRegMapPkg.sv
  - design/symbolTimer.sv
  - design/mfSequencer.sv
  - design/sampleWindow.sv
  - design/complexMac.sv
  - design/coeffBank.sv
  - design/matchFilterTop.sv
  - target: simulation
    files:
      - test/clockGen.sv
      - test/matchFilterTb.sv

// File: design/coeffBank.sv
// coefficient bank, wishbone classic slave with per-symbol set latch and tap read mux
`timescale 1ns/1ps
`default_nettype none

module coeffBank #(
   parameter int NUM_H = 3
) (
   input  wire logic                     clk,
   input  wire logic                     reset,
   input  wire logic                     cyc,
   input  wire logic                     stb,
   input  wire logic                     we,
   input  wire mfRegMapPkg::wbAddr_t     adr,
   input  wire mfRegMapPkg::wbData_t     datIn,
   input  wire demodTypesPkg::hIndex_t   hSel,
   input  wire logic                     symStrobe,
   input  wire demodTypesPkg::tapIndex_t tapIdx,
   output mfRegMapPkg::wbData_t          datOut,
   output logic                          ack,
   output demodTypesPkg::coeff_t         coefRe,
   output demodTypesPkg::coeff_t         coefIm
);

   import demodTypesPkg::*;
   import mfRegMapPkg::*;

   coeff_t    bankRe [NUM_H][NUM_TAPS];
   coeff_t    bankIm [NUM_H][NUM_TAPS];
   hIndex_t   adrSet;
   tapIndex_t adrTap;
   logic      adrIm;
   logic      mapped;
   logic      request;   // new cycle, not yet acknowledged
   coeff_t    rdVal;
   hIndex_t   hCur;      // set in use for this symbol

   // --------------------------------------
   // bus decode
   // --------------------------------------
   assign adrSet  = adr[SET_HI:SET_LO];
   assign adrTap  = adr[TAP_HI:TAP_LO];
   assign adrIm   = adr[IM_BIT];
   assign mapped  = int'(adrSet) < NUM_H;
   assign request = cyc && stb && !ack;

   always_comb begin
      rdVal = '0;   // unmapped sets read zero
      if (mapped) rdVal = adrIm ? bankIm[adrSet][adrTap] : bankRe[adrSet][adrTap];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ack    <= 1'b0;
         datOut <= '0;
         hCur   <= '0;
      end else begin
         ack <= request;
         if (request) datOut <= wbData_t'(rdVal);   // sign-extended
         if (symStrobe) hCur <= hSel;
      end
   end

   // coefficient storage
   always_ff @(posedge clk) begin
      if (request && we && mapped) begin
         if (adrIm) bankIm[adrSet][adrTap] <= coeff_t'(datIn);
         else bankRe[adrSet][adrTap] <= coeff_t'(datIn);
      end
   end

   // --------------------------------------
   // tap read mux
   // --------------------------------------
   always_comb begin
      coefRe = '0;
      coefIm = '0;
      if (int'(hCur) < NUM_H) begin
         coefRe = bankRe[hCur][tapIdx];
         coefIm = bankIm[hCur][tapIdx];
      end
   end

   // master drops stb within the ack cycle, so one request gives one ack
   assert property (@(posedge clk) disable iff (reset)
      ack |-> !stb)
      else $error("coeffBank: stb still high at the end of the ack cycle");

endmodule

`default_nettype wire

// File: design/complexMac.sv
// complex multiply-accumulate, four registered multipliers, accumulators and result combine
`timescale 1ns/1ps
`default_nettype none

module complexMac (
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire demodTypesPkg::sample_t tapI,
   input  wire demodTypesPkg::sample_t tapQ,
   input  wire demodTypesPkg::coeff_t  coefRe,
   input  wire demodTypesPkg::coeff_t  coefIm,
   input  wire logic                   accClear,
   input  wire logic                   accEn,
   input  wire logic                   resultLoad,
   output demodTypesPkg::mfResult_t    mfI,
   output demodTypesPkg::mfResult_t    mfQ,
   output logic                        mfValid
);

   import demodTypesPkg::*;

   localparam int NUM_MAC = 4;

   sample_t  dataOp [NUM_MAC];
   coeff_t   coefOp [NUM_MAC];
   product_t prod   [NUM_MAC];
   acc_t     acc    [NUM_MAC];
   logic     clearD;   // controls lined up with the multiplier stage
   logic     enD;

   // operand pairing
   assign dataOp[0] = tapI;   // re * re
   assign coefOp[0] = coefRe;
   assign dataOp[1] = tapQ;   // im * im
   assign coefOp[1] = coefIm;
   assign dataOp[2] = tapI;   // re * im
   assign coefOp[2] = coefIm;
   assign dataOp[3] = tapQ;   // im * re
   assign coefOp[3] = coefRe;

   // --------------------------------------
   // multipliers and accumulators
   // --------------------------------------
   always_ff @(posedge clk) begin
      for (int m = 0; m < NUM_MAC; m++) begin
         prod[m] <= dataOp[m] * coefOp[m];
         if (clearD) acc[m] <= acc_t'(prod[m]);
         else if (enD) acc[m] <= acc[m] + acc_t'(prod[m]);
      end
   end

   // --------------------------------------
   // control delay and complex combine
   // --------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         clearD  <= 1'b0;
         enD     <= 1'b0;
         mfValid <= 1'b0;
         mfI     <= '0;
         mfQ     <= '0;
      end else begin
         clearD  <= accClear;
         enD     <= accEn;
         mfValid <= resultLoad;   // one cycle after the load edge
         if (resultLoad) begin
            mfI <= mfResult_t'(acc[0]) - mfResult_t'(acc[1]);
            mfQ <= mfResult_t'(acc[2]) + mfResult_t'(acc[3]);
         end
      end
   end

endmodule

`default_nettype wire

// File: design/demodTypesPkg.sv
// demod data types, sample to result widths and tap count for the matched filter
`default_nettype none

package demodTypesPkg;

   // --------------------------------------
   // widths
   // --------------------------------------
   localparam int NUM_TAPS  = 4;
   localparam int SAMPLE_W  = 18;
   localparam int COEFF_W   = 18;
   localparam int PRODUCT_W = SAMPLE_W + COEFF_W;
   localparam int ACC_W     = PRODUCT_W + $clog2(NUM_TAPS);  // growth over 4 taps
   localparam int RESULT_W  = ACC_W + 1;                     // room for re-re minus im-im

   // --------------------------------------
   // data types
   // --------------------------------------
   typedef logic signed [SAMPLE_W-1:0]  sample_t;    // one I or Q sample
   typedef logic signed [COEFF_W-1:0]   coeff_t;     // one coefficient component
   typedef logic signed [PRODUCT_W-1:0] product_t;
   typedef logic signed [ACC_W-1:0]     acc_t;
   typedef logic signed [RESULT_W-1:0]  mfResult_t;  // full precision output

   // tap number
   typedef logic [$clog2(NUM_TAPS)-1:0] tapIndex_t;

   // modulation index select, up to 4 sets
   typedef logic [1:0] hIndex_t;

endpackage

`default_nettype wire

// File: design/matchFilterTop.sv
// multi-h CPM matched filter top, timer, sequencer, sample window, coefficient bank and MACs
`timescale 1ns/1ps
`default_nettype none

module matchFilterTop #(
   parameter int SYM_PERIOD = 12,   // clocks per symbol
   parameter int NUM_H      = 3     // coefficient sets
) (
   input  wire logic                   clk,
   input  wire logic                   reset,
   // wishbone
   input  wire logic                   cyc,
   input  wire logic                   stb,
   input  wire logic                   we,
   input  wire mfRegMapPkg::wbAddr_t   adr,
   input  wire mfRegMapPkg::wbData_t   datIn,
   output mfRegMapPkg::wbData_t        datOut,
   output logic                        ack,
   // samples and set select
   input  wire demodTypesPkg::sample_t sampleI,
   input  wire demodTypesPkg::sample_t sampleQ,
   input  wire demodTypesPkg::hIndex_t hSel,
   output logic                        sampleReq,
   output logic                        symStrobe,
   // results
   output demodTypesPkg::mfResult_t    mfI,
   output demodTypesPkg::mfResult_t    mfQ,
   output logic                        mfValid
);

   import demodTypesPkg::*;

   tapIndex_t tapIdx;
   logic      accClear;
   logic      accEn;
   logic      resultLoad;
   sample_t   tapI;
   sample_t   tapQ;
   coeff_t    coefRe;
   coeff_t    coefIm;

   // --------------------------------------
   // control
   // --------------------------------------
   symbolTimer #(.SYM_PERIOD(SYM_PERIOD)) uTimer (
      .clk(clk), .reset(reset), .sampleReq(sampleReq), .symStrobe(symStrobe)
   );

   mfSequencer uSeq (
      .clk(clk), .reset(reset), .symStrobe(symStrobe), .tapIdx(tapIdx),
      .accClear(accClear), .accEn(accEn), .resultLoad(resultLoad)
   );

   // --------------------------------------
   // data path
   // --------------------------------------
   sampleWindow uWindow (
      .clk(clk), .reset(reset), .sampleReq(sampleReq), .symStrobe(symStrobe),
      .sampleI(sampleI), .sampleQ(sampleQ), .tapIdx(tapIdx), .tapI(tapI), .tapQ(tapQ)
   );

   coeffBank #(.NUM_H(NUM_H)) uBank (
      .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
      .datIn(datIn), .hSel(hSel), .symStrobe(symStrobe), .tapIdx(tapIdx),
      .datOut(datOut), .ack(ack), .coefRe(coefRe), .coefIm(coefIm)
   );

   complexMac uMac (
      .clk(clk), .reset(reset), .tapI(tapI), .tapQ(tapQ), .coefRe(coefRe),
      .coefIm(coefIm), .accClear(accClear), .accEn(accEn), .resultLoad(resultLoad),
      .mfI(mfI), .mfQ(mfQ), .mfValid(mfValid)
   );

endmodule

`default_nettype wire

// File: design/mfRegMapPkg.sv
// wishbone register map of the coefficient bank, bus widths and address fields
`default_nettype none

package mfRegMapPkg;

   localparam int WB_ADDR_W = 5;   // word address
   localparam int WB_DATA_W = 32;

   typedef logic [WB_ADDR_W-1:0] wbAddr_t;
   typedef logic [WB_DATA_W-1:0] wbData_t;

   // --------------------------------------
   // address fields
   // --------------------------------------
   localparam int SET_HI = 4;   // coefficient set
   localparam int SET_LO = 3;
   localparam int TAP_HI = 2;   // tap within the set
   localparam int TAP_LO = 1;
   localparam int IM_BIT = 0;   // 0 real, 1 imaginary

   // word address of one coefficient component
   function automatic wbAddr_t coefAddr(input logic [1:0] set,
                                        input logic [1:0] tap,
                                        input logic im);
      return {set, tap, im};
   endfunction

endpackage

`default_nettype wire

// File: design/mfSequencer.sv
// matched filter sequencer, steps the taps and times accumulate and result load
`timescale 1ns/1ps
`default_nettype none

module mfSequencer (
   input  wire logic                clk,
   input  wire logic                reset,
   input  wire logic                symStrobe,
   output demodTypesPkg::tapIndex_t tapIdx,
   output logic                     accClear,
   output logic                     accEn,
   output logic                     resultLoad
);

   import demodTypesPkg::*;

   typedef enum logic [1:0] {
      IDLE,    // wait for the symbol
      TAPS,    // present taps 0 to 3
      DRAIN,   // last product still in the multiplier stage
      LOAD     // sums complete
   } seqState_t;

   localparam tapIndex_t LAST_TAP = tapIndex_t'(NUM_TAPS - 1);

   seqState_t state;

   // --------------------------------------
   // state and tap counter
   // --------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= IDLE;
         tapIdx <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (symStrobe) begin
                  state  <= TAPS;
                  tapIdx <= '0;   // oldest sample first
               end
            end
            TAPS: begin
               if (tapIdx == LAST_TAP) state <= DRAIN;
               else tapIdx <= tapIdx + 1'b1;
            end
            DRAIN:   state <= LOAD;
            LOAD:    state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   assign accClear   = (state == TAPS) && (tapIdx == '0);   // first product loads
   assign accEn      = (state == TAPS) && (tapIdx != '0);
   assign resultLoad = (state == LOAD);

   // clear alone, three adds, one drain cycle, then the load
   assert property (@(posedge clk) disable iff (reset)
      accClear |-> !accEn ##1 accEn [*3] ##1 (!accEn && !accClear) ##1 resultLoad)
      else $error("mfSequencer: accumulate schedule broken");

endmodule

`default_nettype wire

// File: design/sampleWindow.sv
// sample window, I/Q delay line with per-symbol snapshot and tap-ordered read mux
`timescale 1ns/1ps
`default_nettype none

module sampleWindow (
   input  wire logic                      clk,
   input  wire logic                      reset,
   input  wire logic                      sampleReq,
   input  wire logic                      symStrobe,
   input  wire demodTypesPkg::sample_t    sampleI,
   input  wire demodTypesPkg::sample_t    sampleQ,
   input  wire demodTypesPkg::tapIndex_t  tapIdx,
   output demodTypesPkg::sample_t         tapI,
   output demodTypesPkg::sample_t         tapQ
);

   import demodTypesPkg::*;

   localparam tapIndex_t OLDEST = tapIndex_t'(NUM_TAPS - 1);

   sample_t   lineI [NUM_TAPS];   // index 0 newest
   sample_t   lineQ [NUM_TAPS];
   sample_t   snapI [NUM_TAPS];   // frozen for one symbol
   sample_t   snapQ [NUM_TAPS];
   tapIndex_t snapSel;

   // --------------------------------------
   // delay line and snapshot
   // --------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         lineI <= '{default: '0};
         lineQ <= '{default: '0};
         snapI <= '{default: '0};
         snapQ <= '{default: '0};
      end else begin
         if (sampleReq) begin
            lineI[0] <= sampleI;
            lineQ[0] <= sampleQ;
            for (int k = 1; k < NUM_TAPS; k++) begin
               lineI[k] <= lineI[k-1];
               lineQ[k] <= lineQ[k-1];
            end
         end
         // old line contents, the sample shifting in now waits for the next symbol
         if (symStrobe) begin
            snapI <= lineI;
            snapQ <= lineQ;
         end
      end
   end

   assign snapSel = OLDEST - tapIdx;   // tap 0 reads the oldest
   assign tapI    = snapI[snapSel];
   assign tapQ    = snapQ[snapSel];

endmodule

`default_nettype wire

// File: design/symbolTimer.sv
// symbol timer, free-running sample-request and symbol strobes from the symbol period
`timescale 1ns/1ps
`default_nettype none

module symbolTimer #(
   parameter int SYM_PERIOD = 12
) (
   input  wire logic clk,
   input  wire logic reset,
   output logic      sampleReq,
   output logic      symStrobe
);

   localparam int HALF  = SYM_PERIOD / 2;   // clocks per sample
   localparam int CNT_W = $clog2(HALF);

   logic [CNT_W-1:0] cnt;
   logic             phase;   // high when the next reload is a symbol

   if (SYM_PERIOD < 10 || (SYM_PERIOD % 2) != 0) begin : gPeriodCheck
      $error("symbolTimer: SYM_PERIOD must be even and at least 10");
   end

   // --------------------------------------
   // down-counter, reload marks a sample
   // --------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         cnt       <= CNT_W'(HALF - 1);
         phase     <= 1'b0;
         sampleReq <= 1'b0;
         symStrobe <= 1'b0;
      end else if (cnt == '0) begin
         cnt       <= CNT_W'(HALF - 1);
         sampleReq <= 1'b1;
         symStrobe <= phase;   // every second sample
         phase     <= ~phase;
      end else begin
         cnt       <= cnt - 1'b1;
         sampleReq <= 1'b0;
         symStrobe <= 1'b0;
      end
   end

   // symbol rides on a sample, the next sample is half a period on, the next symbol a period
   assert property (@(posedge clk) disable iff (reset)
      symStrobe |-> sampleReq ##HALF (sampleReq && !symStrobe) ##HALF symStrobe)
      else $error("symbolTimer: strobe spacing broken");

endmodule

`default_nettype wire

// File: mfDemod.f
design/demodTypesPkg.sv
design/mfRegMapPkg.sv
design/symbolTimer.sv
design/mfSequencer.sv
design/sampleWindow.sv
design/complexMac.sv
design/coeffBank.sv
design/matchFilterTop.sv
test/clockGen.sv
test/matchFilterTb.sv

// File: test/clockGen.sv
// testbench clock source, free-running square wave with a set period
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
   parameter int PERIOD_NS = 4
) (
   output logic clk
);

   initial clk = 1'b0;

   always #(PERIOD_NS / 2.0) clk = ~clk;   // half period per phase

endmodule

`default_nettype wire

// File: test/matchFilterTb.sv
// matched filter testbench, table-driven symbols checked against a complex correlation model
`timescale 1ns/1ps
`default_nettype none

module matchFilterTb;

   import demodTypesPkg::*;
   import mfRegMapPkg::*;

   localparam int SYM_PERIOD   = 12;
   localparam int NUM_H        = 3;
   localparam int LATENCY      = 7;   // symStrobe to mfValid
   localparam int MAX_ROWS     = 16;
   localparam int MAX_COEF     = 4;
   localparam int WB_OP_CYCLES = 3;
   localparam int FIXED        = 0;   // sample modes
   localparam int RAND_FULL    = 1;
   localparam int RAND_EXT     = 2;
   localparam int S_MAX        = 131071;
   localparam int S_MIN        = -131072;

   logic      clk;
   logic      reset;
   logic      cyc;
   logic      stb;
   logic      we;
   logic      ack;
   wbAddr_t   adr;
   wbData_t   datIn;
   wbData_t   datOut;
   sample_t   sampleI;
   sample_t   sampleQ;
   hIndex_t   hSel;
   logic      sampleReq;
   logic      symStrobe;
   mfResult_t mfI;
   mfResult_t mfQ;
   logic      mfValid;

   // ----------------------------------------
   // stimulus table and bank model
   // ----------------------------------------
   string  rowName [MAX_ROWS];
   int     rowLoad [MAX_ROWS];   // coefficient entry to write first, -1 none
   int     rowMode [MAX_ROWS];
   int     rowI    [MAX_ROWS][NUM_TAPS];   // oldest sample first
   int     rowQ    [MAX_ROWS][NUM_TAPS];
   int     rowH    [MAX_ROWS];
   int     numRows;
   int     tabSet  [MAX_COEF];
   int     tabRe   [MAX_COEF][NUM_TAPS];
   int     tabIm   [MAX_COEF][NUM_TAPS];
   int     numCoef;
   int     numLoads;
   logic   tableReady;
   longint modelRe [4][NUM_TAPS];
   longint modelIm [4][NUM_TAPS];
   int     errCount;
   int     checkCount;
   int     seed;
   int     cycNum;       // monitor state
   int     lastStrobe;
   logic   prevValid;

   clockGen #(.PERIOD_NS(4)) uClk (.clk(clk));

   matchFilterTop #(.SYM_PERIOD(SYM_PERIOD), .NUM_H(NUM_H)) UUT (
      .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
      .datIn(datIn), .datOut(datOut), .ack(ack), .sampleI(sampleI), .sampleQ(sampleQ),
      .hSel(hSel), .sampleReq(sampleReq), .symStrobe(symStrobe),
      .mfI(mfI), .mfQ(mfQ), .mfValid(mfValid)
   );

   task automatic checkVal(input string name, input longint expVal, input longint actVal);
      checkCount++;
      if (expVal != actVal) begin
         errCount++;
         $display("ERR %s expected %0d actual %0d", name, expVal, actVal);
      end
   endtask

   task automatic nextCycle;
      @(posedge clk);
      #1;   // drive and sample just after the edge
   endtask

   task automatic addCoef(input int set, input int re [NUM_TAPS], input int im [NUM_TAPS]);
      tabSet[numCoef] = set;
      tabRe[numCoef]  = re;
      tabIm[numCoef]  = im;
      numCoef++;
   endtask

   task automatic addRow(input string name, input int load, input int mode,
                         input int si [NUM_TAPS], input int sq [NUM_TAPS], input int h);
      rowName[numRows] = name;
      rowLoad[numRows] = load;
      rowMode[numRows] = mode;
      rowI[numRows]    = si;
      rowQ[numRows]    = sq;
      rowH[numRows]    = h;
      if (load >= 0) numLoads++;
      numRows++;
   endtask

   task automatic buildTable;
      numRows  = 0;
      numCoef  = 0;
      numLoads = 0;
      addCoef(0, '{1000, -2000, 3000, -4000}, '{500, 600, -700, 800});
      addCoef(1, '{S_MIN, S_MAX, 7, -9}, '{12345, -54321, 0, 77});
      addCoef(2, '{-3, 99999, -100000, 250}, '{S_MIN, 1, 2, S_MAX});
      addCoef(2, '{S_MIN, S_MAX, S_MIN, S_MAX}, '{S_MAX, S_MIN, S_MIN, S_MAX});
      // single impulses walk the taps
      addRow("impulse_tap0", 0, FIXED, '{1, 0, 0, 0}, '{0, 0, 0, 0}, 0);
      addRow("impulse_tap1", -1, FIXED, '{0, 1, 0, 0}, '{0, 0, 0, 0}, 0);
      addRow("impulse_tap2", -1, FIXED, '{0, 0, 0, 0}, '{0, 0, 1, 0}, 0);
      addRow("impulse_tap3", -1, FIXED, '{0, 0, 0, 1}, '{0, 0, 0, 1}, 0);
      addRow("multi_h_set0", 1, FIXED, '{300, -400, 500, -600}, '{-70, 80, 90, -100}, 0);
      addRow("multi_h_set1", 2, FIXED, '{300, -400, 500, -600}, '{-70, 80, 90, -100}, 1);
      addRow("multi_h_set2", -1, FIXED, '{300, -400, 500, -600}, '{-70, 80, 90, -100}, 2);
      addRow("full_scale", 3, FIXED, '{S_MIN, S_MAX, S_MIN, S_MAX},
             '{S_MIN, S_MAX, S_MAX, S_MIN}, 2);
      addRow("random_extremes", -1, RAND_EXT, '{0, 0, 0, 0}, '{0, 0, 0, 0}, 2);
      addRow("random_set0", -1, RAND_FULL, '{0, 0, 0, 0}, '{0, 0, 0, 0}, 0);
      addRow("random_set1", -1, RAND_FULL, '{0, 0, 0, 0}, '{0, 0, 0, 0}, 1);
      tableReady = 1'b1;
   endtask

   function automatic int randSample(input int mode);
      int r;
      r = $random(seed);
      if (mode == RAND_EXT) return r[0] ? S_MAX : S_MIN;
      return int'(sample_t'(r));   // any 18-bit value
   endfunction

   // set in 4:3, tap in 2:1, imaginary flag in bit 0
   function automatic wbAddr_t adrOf(input int set, input int tap, input logic im);
      return wbAddr_t'({set[1:0], tap[1:0], im});
   endfunction

   // ----------------------------------------
   // wishbone master
   // ----------------------------------------
   task automatic busCycle(input wbAddr_t a, input logic write, input wbData_t d,
                           output wbData_t rd);
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = write;
      adr   = a;
      datIn = d;
      nextCycle();
      checkVal("wb_ack", 1, ack);
      rd  = datOut;
      cyc = 1'b0;   // ack seen, cycle done
      stb = 1'b0;
      we  = 1'b0;
      nextCycle();
      checkVal("wb_ack_single", 0, ack);
   endtask

   task automatic writeCoefSet(input int e);
      wbData_t rd;
      int      val;
      for (int tap = 0; tap < NUM_TAPS; tap++) begin
         for (int im = 0; im < 2; im++) begin
            val = (im != 0) ? tabIm[e][tap] : tabRe[e][tap];
            busCycle(adrOf(tabSet[e], tap, im[0]), 1'b1, {14'h155A, val[17:0]}, rd);
            if (im != 0) modelIm[tabSet[e]][tap] = val;
            else modelRe[tabSet[e]][tap] = val;
         end
      end
      for (int tap = 0; tap < NUM_TAPS; tap++) begin
         for (int im = 0; im < 2; im++) begin
            val = (im != 0) ? tabIm[e][tap] : tabRe[e][tap];
            busCycle(adrOf(tabSet[e], tap, im[0]), 1'b0, '0, rd);
            checkVal("wb_readback", longint'(wbData_t'(val)), longint'(rd));
         end
      end
   endtask

   task automatic checkIdle(input string name);
      checkVal({name, "_flags"}, 0, longint'({mfValid, ack, sampleReq, symStrobe}));
      checkVal({name, "_mfI"}, 0, mfI);
      checkVal({name, "_mfQ"}, 0, mfQ);
   endtask

   task automatic waitSampleReq(input logic wantStrobe);
      int n;
      n = 0;
      do begin
         nextCycle();
         n++;
      end while (!(sampleReq && (symStrobe || !wantStrobe)) && n < 2 * SYM_PERIOD);
      if (!(sampleReq && (symStrobe || !wantStrobe))) begin
         errCount++;
         $display("no sample request seen within %0d cycles", 2 * SYM_PERIOD);
      end
   endtask

   task automatic runRow(input int r);
      int      si [NUM_TAPS];
      int      sq [NUM_TAPS];
      longint  expI;
      longint  expQ;
      int      h;
      int      n;
      hIndex_t decoy;
      if (rowLoad[r] >= 0) writeCoefSet(rowLoad[r]);
      h     = rowH[r];
      decoy = hIndex_t'(h) ^ 2'b01;   // any other set outside the checked strobe
      for (int k = 0; k < NUM_TAPS; k++) begin
         si[k] = (rowMode[r] == FIXED) ? rowI[r][k] : randSample(rowMode[r]);
         sq[k] = (rowMode[r] == FIXED) ? rowQ[r][k] : randSample(rowMode[r]);
      end
      // complex correlation, tap 0 against the oldest sample
      expI = 0;
      expQ = 0;
      for (int k = 0; k < NUM_TAPS; k++) begin
         expI += longint'(si[k]) * modelRe[h][k] - longint'(sq[k]) * modelIm[h][k];
         expQ += longint'(si[k]) * modelIm[h][k] + longint'(sq[k]) * modelRe[h][k];
      end
      hSel = decoy;
      for (int k = 0; k < NUM_TAPS; k++) begin
         waitSampleReq(k == 0);
         sampleI = sample_t'(si[k]);
         sampleQ = sample_t'(sq[k]);
      end
      waitSampleReq(1'b1);   // strobe that closes the window
      hSel    = hIndex_t'(h);
      sampleI = '0;
      sampleQ = '0;
      nextCycle();
      hSel = decoy;
      n    = 1;
      while (!mfValid && n < 2 * LATENCY) begin
         nextCycle();
         n++;
      end
      if (!mfValid) begin
         errCount++;
         $display("mfValid never came for row %s", rowName[r]);
      end else begin
         checkVal({rowName[r], "_latency"}, LATENCY, n);
         checkVal({rowName[r], "_mfI"}, expI, mfI);
         checkVal({rowName[r], "_mfQ"}, expQ, mfQ);
      end
   endtask

   // ----------------------------------------
   // strobe spacing and valid timing, every symbol
   // ----------------------------------------
   always @(negedge clk) begin
      if (reset) begin
         cycNum     = 0;
         lastStrobe = -1;
         prevValid  = 1'b0;
      end else begin
         cycNum++;
         if (symStrobe) begin
            if (lastStrobe >= 0) checkVal("sym_period", SYM_PERIOD, cycNum - lastStrobe);
            lastStrobe = cycNum;
         end
         if (mfValid) begin
            checkVal("valid_latency", LATENCY, cycNum - lastStrobe);
            checkVal("valid_width", 0, prevValid);
         end
         prevValid = mfValid;
      end
   end

   initial begin : mainSeq
      wbData_t rd;
      seed       = 98;
      errCount   = 0;
      checkCount = 0;
      tableReady = 1'b0;
      reset      = 1'b1;
      cyc        = 1'b0;
      stb        = 1'b0;
      we         = 1'b0;
      adr        = '0;
      datIn      = '0;
      sampleI    = '0;
      sampleQ    = '0;
      hSel       = '0;
      buildTable();
      repeat (5) begin
         nextCycle();
         checkIdle("reset_hold");
      end
      reset = 1'b0;
      nextCycle();
      checkIdle("reset_release");
      // set 3 is past NUM_H
      busCycle(adrOf(3, 1, 1'b0), 1'b1, 32'h0001_2345, rd);
      busCycle(adrOf(3, 1, 1'b0), 1'b0, '0, rd);
      checkVal("wb_unmapped_read", 0, rd);
      for (int r = 0; r < numRows; r++) runRow(r);
      nextCycle();
      $display("checks %0d errors %0d", checkCount, errCount);
      if (errCount == 0) $display("All checks passed");
      else $display("Checks failed");
      $finish;
   end

   initial begin : watchdog
      int limit;
      wait (tableReady);
      limit = numRows * 4 * SYM_PERIOD + (numLoads * 4 * NUM_TAPS + 4) * WB_OP_CYCLES + 20;
      repeat (limit) @(posedge clk);
      $display("timeout, run did not finish within %0d clock cycles", limit);
      $display("checks %0d errors %0d", checkCount, errCount);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire
